//--- common/fetch_pkg.sv
package fetch_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // one buffer slot
  typedef struct packed {
    addr_t  pc;
    instr_t instr;
  } ib_entry_t;

  // decode-side pop request
  typedef enum logic [1:0] {
    POP_NONE = 2'd0,
    POP_ONE  = 2'd1,
    POP_TWO  = 2'd2
  } pop_op_e;

  localparam int LINE_WORDS = 4;
  localparam int LINE_BYTES = 16;

  // AR fields for one line fill
  localparam logic [7:0] AR_LEN_LINE   = 8'd3;
  localparam logic [2:0] AR_SIZE_WORD  = 3'd2;
  localparam logic [1:0] AR_BURST_INCR = 2'd1;

endpackage

//--- fetch/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen import fetch_pkg::*; #(
  parameter addr_t RESET_PC = 32'h1c00_0000,
  parameter int    IB_DEPTH = 8
) (
  input  logic                      aclk,
  input  logic                      reset,
  input  logic                      jump_valid,
  input  addr_t                     jump_pc,
  input  logic [$clog2(IB_DEPTH):0] free_slots,
  input  logic                      bridge_busy,
  output logic                      fetch_req,
  output addr_t                     fetch_addr,
  output logic [1:0]                fetch_skip
);

  localparam int OFFS_W = $clog2(LINE_BYTES);

  addr_t      line_pc;
  logic [1:0] skip_q;

  // one line in flight, and room for all of it
  assign fetch_req = !jump_valid && !bridge_busy && (free_slots >= LINE_WORDS);

  assign fetch_addr = line_pc;
  assign fetch_skip = skip_q;

  always_ff @(posedge aclk) begin
    if (reset) begin
      line_pc <= RESET_PC;
      skip_q  <= 2'd0;
    end else if (jump_valid) begin
      line_pc <= {jump_pc[31:OFFS_W], {OFFS_W{1'b0}}};
      // words before the target are dropped by the buffer
      skip_q  <= jump_pc[OFFS_W-1:2];
    end else if (fetch_req) begin
      line_pc <= line_pc + addr_t'(LINE_BYTES);
      skip_q  <= 2'd0;
    end
  end

  a_line_aligned: assert property (
    @(posedge aclk) disable iff (reset)
    fetch_req |-> (fetch_addr[OFFS_W-1:0] == '0)
  ) else $error("fetch_addr 0x%08h not line aligned", fetch_addr);

endmodule

//--- fetch/axi_fetch_bridge.sv
`timescale 1ns/1ps

module axi_fetch_bridge import fetch_pkg::*; (
  input  logic                    aclk,
  input  logic                    reset,
  input  logic                    jump_valid,
  // line request from pc gen
  input  logic                    fetch_req,
  input  addr_t                   fetch_addr,
  input  logic [1:0]              fetch_skip,
  output logic                    bridge_busy,
  // filled line to the buffer
  output logic                    line_valid,
  output instr_t [LINE_WORDS-1:0] line_data,
  output addr_t                   line_addr,
  output logic [1:0]              line_skip,
  // AXI read
  output addr_t                   araddr,
  output logic [7:0]              arlen,
  output logic [2:0]              arsize,
  output logic [1:0]              arburst,
  output logic [3:0]              arid,
  output logic                    arvalid,
  input  logic                    arready,
  input  logic [31:0]             rdata,
  input  logic                    rlast,
  input  logic                    rvalid,
  output logic                    rready
);

  typedef enum logic [1:0] {
    BR_IDLE,
    BR_ADDR,
    BR_DATA,
    BR_DRAIN
  } bridge_state_e;

  bridge_state_e state;
  logic          ar_pending;
  logic [1:0]    beat_cnt;
  logic          ar_fire;
  logic          r_fire;

  assign ar_fire = arvalid && arready;
  assign r_fire  = rvalid && rready;

  assign araddr  = line_addr;
  assign arlen   = AR_LEN_LINE;
  assign arsize  = AR_SIZE_WORD;
  assign arburst = AR_BURST_INCR;
  assign arid    = 4'd0;
  assign arvalid = ar_pending;

  // a drained burst may still owe its AR handshake
  assign rready = ((state == BR_DATA) || (state == BR_DRAIN)) && !ar_pending;

  // held through the strobe cycle so free_slots has caught up
  assign bridge_busy = (state != BR_IDLE) || line_valid;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state      <= BR_IDLE;
      ar_pending <= 1'b0;
      beat_cnt   <= 2'd0;
      line_valid <= 1'b0;
    end else begin
      line_valid <= 1'b0;
      if (ar_fire) begin
        ar_pending <= 1'b0;
      end
      if (r_fire) begin
        beat_cnt <= beat_cnt + 2'd1;
      end
      case (state)
        BR_IDLE: begin
          if (fetch_req) begin
            state      <= BR_ADDR;
            ar_pending <= 1'b1;
            beat_cnt   <= 2'd0;
          end
        end
        BR_ADDR: begin
          if (jump_valid) begin
            state <= BR_DRAIN;
          end else if (ar_fire) begin
            state <= BR_DATA;
          end
        end
        BR_DATA: begin
          if (r_fire && rlast) begin
            state      <= BR_IDLE;
            line_valid <= !jump_valid;
          end else if (jump_valid) begin
            state <= BR_DRAIN;
          end
        end
        BR_DRAIN: begin
          // stale beats are accepted and dropped
          if (r_fire && rlast) begin
            state <= BR_IDLE;
          end
        end
        default: state <= BR_IDLE;
      endcase
    end
  end

  // request fields and line payload
  always_ff @(posedge aclk) begin
    if (fetch_req && (state == BR_IDLE)) begin
      line_addr <= fetch_addr;
      line_skip <= fetch_skip;
    end
    if (r_fire && (state == BR_DATA)) begin
      line_data[beat_cnt] <= rdata;
    end
  end

  a_ar_stable: assert property (
    @(posedge aclk) disable iff (reset)
    (arvalid && !arready) |=> (arvalid && $stable(araddr))
  ) else $error("araddr or arvalid changed before AR handshake");

  a_rlast_beat: assert property (
    @(posedge aclk) disable iff (reset)
    r_fire |-> (rlast == (beat_cnt == 2'd3))
  ) else $error("rlast not on the fourth beat, beat_cnt %0d", beat_cnt);

endmodule

//--- fetch/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer import fetch_pkg::*; #(
  parameter int IB_DEPTH = 8
) (
  input  logic                      aclk,
  input  logic                      reset,
  input  logic                      jump_valid,
  input  pop_op_e                   pop_op,
  // line from the bridge
  input  logic                      line_valid,
  input  instr_t [LINE_WORDS-1:0]   line_data,
  input  addr_t                     line_addr,
  input  logic [1:0]                line_skip,
  output logic [$clog2(IB_DEPTH):0] free_slots,
  // oldest two entries
  output instr_t                    instr0,
  output addr_t                     instr0_pc,
  output logic                      instr0_valid,
  output instr_t                    instr1,
  output addr_t                     instr1_pc,
  output logic                      instr1_valid
);

  localparam int PTR_W = $clog2(IB_DEPTH);

  ib_entry_t        mem [IB_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;
  logic [PTR_W-1:0] head_nx1;
  logic [2:0]       push_n;
  logic [1:0]       pop_n;

  logic [PTR_W-1:0] wr_idx   [LINE_WORDS];
  ib_entry_t        wr_entry [LINE_WORDS];
  logic [1:0]       word_idx [LINE_WORDS];

  assign head_nx1   = head + PTR_W'(1);
  assign free_slots = (PTR_W+1)'(IB_DEPTH) - count;

  assign instr0       = mem[head].instr;
  assign instr0_pc    = mem[head].pc;
  assign instr0_valid = (count != '0);
  assign instr1       = mem[head_nx1].instr;
  assign instr1_pc    = mem[head_nx1].pc;
  assign instr1_valid = (count > (PTR_W+1)'(1));

  // never pop more than what is valid
  always_comb begin
    case (pop_op)
      POP_ONE: pop_n = instr0_valid ? 2'd1 : 2'd0;
      POP_TWO: pop_n = instr1_valid ? 2'd2 : (instr0_valid ? 2'd1 : 2'd0);
      default: pop_n = 2'd0;
    endcase
  end

  assign push_n = line_valid ? (3'(LINE_WORDS) - {1'b0, line_skip}) : 3'd0;

  // slot i takes word line_skip+i of the line
  always_comb begin
    for (int i = 0; i < LINE_WORDS; i++) begin
      word_idx[i] = line_skip + 2'(i);
      wr_idx[i]   = tail + PTR_W'(i);
      wr_entry[i] = '{pc: line_addr + addr_t'({word_idx[i], 2'b00}),
                      instr: line_data[word_idx[i]]};
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (jump_valid) begin
      // flush also drops the pop of this cycle
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + PTR_W'(pop_n);
      tail  <= tail + PTR_W'(push_n);
      count <= count + (PTR_W+1)'(push_n) - (PTR_W+1)'(pop_n);
    end
  end

  always_ff @(posedge aclk) begin
    if (!jump_valid) begin
      for (int i = 0; i < LINE_WORDS; i++) begin
        if (3'(i) < push_n) begin
          mem[wr_idx[i]] <= wr_entry[i];
        end
      end
    end
  end

  // pc gen only issues a line when a full one fits
  a_push_room: assert property (
    @(posedge aclk) disable iff (reset)
    line_valid |-> (free_slots >= LINE_WORDS)
  ) else $error("line push with only %0d free slots", free_slots);

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter addr_t RESET_PC = 32'h1c00_0000,
  parameter int    IB_DEPTH = 8
) (
  input  logic        aclk,
  input  logic        reset,
  // redirect
  input  logic        jump_valid,
  input  addr_t       jump_pc,
  // decode side
  input  pop_op_e     pop_op,
  output instr_t      instr0,
  output addr_t       instr0_pc,
  output logic        instr0_valid,
  output instr_t      instr1,
  output addr_t       instr1_pc,
  output logic        instr1_valid,
  // AXI read address
  output addr_t       araddr,
  output logic [7:0]  arlen,
  output logic [2:0]  arsize,
  output logic [1:0]  arburst,
  output logic [3:0]  arid,
  output logic        arvalid,
  input  logic        arready,
  // AXI read data
  input  logic [31:0] rdata,
  input  logic        rlast,
  input  logic        rvalid,
  output logic        rready
);

  logic                        fetch_req;
  addr_t                       fetch_addr;
  logic [1:0]                  fetch_skip;
  logic                        bridge_busy;
  logic                        line_valid;
  instr_t [LINE_WORDS-1:0]     line_data;
  addr_t                       line_addr;
  logic [1:0]                  line_skip;
  logic [$clog2(IB_DEPTH):0]   free_slots;

  fetch_pc_gen #(
    .RESET_PC (RESET_PC),
    .IB_DEPTH (IB_DEPTH)
  ) u_pc_gen (
    .aclk        (aclk),
    .reset       (reset),
    .jump_valid  (jump_valid),
    .jump_pc     (jump_pc),
    .free_slots  (free_slots),
    .bridge_busy (bridge_busy),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_skip  (fetch_skip)
  );

  axi_fetch_bridge u_bridge (
    .aclk        (aclk),
    .reset       (reset),
    .jump_valid  (jump_valid),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_skip  (fetch_skip),
    .bridge_busy (bridge_busy),
    .line_valid  (line_valid),
    .line_data   (line_data),
    .line_addr   (line_addr),
    .line_skip   (line_skip),
    .araddr      (araddr),
    .arlen       (arlen),
    .arsize      (arsize),
    .arburst     (arburst),
    .arid        (arid),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rlast       (rlast),
    .rvalid      (rvalid),
    .rready      (rready)
  );

  instr_buffer #(
    .IB_DEPTH (IB_DEPTH)
  ) u_ibuf (
    .aclk         (aclk),
    .reset        (reset),
    .jump_valid   (jump_valid),
    .pop_op       (pop_op),
    .line_valid   (line_valid),
    .line_data    (line_data),
    .line_addr    (line_addr),
    .line_skip    (line_skip),
    .free_slots   (free_slots),
    .instr0       (instr0),
    .instr0_pc    (instr0_pc),
    .instr0_valid (instr0_valid),
    .instr1       (instr1),
    .instr1_pc    (instr1_pc),
    .instr1_valid (instr1_valid)
  );

endmodule

//--- verification/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker import fetch_pkg::*; #(
  parameter addr_t RESET_PC = 32'h1c00_0000
) (
  input  logic       aclk,
  input  logic       reset,
  input  logic       jump_valid,
  input  addr_t      jump_pc,
  input  pop_op_e    pop_op,
  input  instr_t     instr0,
  input  addr_t      instr0_pc,
  input  logic       instr0_valid,
  input  instr_t     instr1,
  input  addr_t      instr1_pc,
  input  logic       instr1_valid,
  input  addr_t      araddr,
  input  logic [7:0] arlen,
  input  logic [2:0] arsize,
  input  logic [1:0] arburst,
  input  logic [3:0] arid,
  input  logic       arvalid,
  input  logic       arready,
  input  logic       rlast,
  input  logic       rvalid,
  input  logic       rready,
  output int         errors,
  output int         popped
);

  addr_t exp_pc;
  addr_t last_araddr;
  bit    ar_wait;
  bit    first_ar;
  bit    flush_chk;
  int    outstanding;

  initial begin
    errors = 0;
    popped = 0;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic complain(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic check_ar();
    if (ar_wait) begin
      compare("arvalid", arvalid, 32'd1);
      compare("araddr", araddr, last_araddr);
    end
    if (rvalid && rready && rlast) begin
      outstanding--;
    end
    if (arvalid) begin
      compare("arlen", arlen, AR_LEN_LINE);
      compare("arsize", arsize, AR_SIZE_WORD);
      compare("arburst", arburst, AR_BURST_INCR);
      compare("arid", arid, 32'd0);
      compare("araddr line offset", araddr % LINE_BYTES, 32'd0);
      if (first_ar) begin
        compare("araddr", araddr, RESET_PC);
      end
      first_ar = 1'b0;
      if (arready) begin
        if (outstanding != 0) begin
          complain("second AR accepted while a burst is still outstanding");
        end
        outstanding++;
      end
    end
    ar_wait = arvalid && !arready;
    last_araddr = araddr;
  endtask

  // one popped slot against the program order
  task automatic check_slot(input string slot, input addr_t pc, input instr_t instr);
    compare({slot, "_pc"}, pc, exp_pc);
    compare(slot, instr, ~exp_pc);
    // resync so a slip is reported once
    if (pc !== exp_pc) begin
      exp_pc = pc;
    end
    exp_pc = exp_pc + 32'd4;
    popped++;
  endtask

  task automatic check_pops();
    int n;
    if (flush_chk) begin
      compare("instr0_valid", instr0_valid, 32'd0);
      compare("instr1_valid", instr1_valid, 32'd0);
    end
    flush_chk = jump_valid;
    if (instr1_valid && !instr0_valid) begin
      complain("instr1_valid is high while instr0_valid is low");
    end
    if (jump_valid) begin
      exp_pc = jump_pc;
    end else begin
      n = (pop_op == POP_TWO) ? 2 : ((pop_op == POP_ONE) ? 1 : 0);
      if (n >= 1 && instr0_valid) begin
        check_slot("instr0", instr0_pc, instr0);
      end
      if (n >= 2 && instr0_valid && instr1_valid) begin
        check_slot("instr1", instr1_pc, instr1);
      end
    end
  endtask

  // sampled mid-cycle, away from both edges of the stimulus
  always @(negedge aclk) begin
    if (reset) begin
      exp_pc = RESET_PC;
      first_ar = 1'b1;
      ar_wait = 1'b0;
      flush_chk = 1'b0;
      outstanding = 0;
      compare("arvalid", arvalid, 32'd0);
      compare("rready", rready, 32'd0);
      compare("instr0_valid", instr0_valid, 32'd0);
      compare("instr1_valid", instr1_valid, 32'd0);
    end else begin
      check_ar();
      check_pops();
    end
  end

endmodule

//--- verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

  localparam addr_t RESET_PC = 32'h1c00_0000;

  logic        aclk;
  logic        reset;
  logic        jump_valid;
  addr_t       jump_pc;
  pop_op_e     pop_op;
  instr_t      instr0;
  addr_t       instr0_pc;
  logic        instr0_valid;
  instr_t      instr1;
  addr_t       instr1_pc;
  logic        instr1_valid;
  addr_t       araddr;
  logic [7:0]  arlen;
  logic [2:0]  arsize;
  logic [1:0]  arburst;
  logic [3:0]  arid;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic        rlast;
  logic        rvalid;
  logic        rready;

  int          errors;
  int          popped;
  logic [31:0] lfsr;
  logic [31:0] pop_sel;
  addr_t       bursts[$];
  int          beat;
  logic        ar_hs;
  logic        r_hs;
  addr_t       ar_addr_s;
  bit          stall;
  bit          jumps_on;
  int          jump_count;
  int          fails;
  int          err_base;
  bit          test_bad;

  fetch_top #(.RESET_PC (RESET_PC), .IB_DEPTH (8)) dut (.*);

  fetch_checker #(.RESET_PC (RESET_PC)) u_checker (.*);

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  // galois form stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  always @(negedge aclk) begin
    ar_hs     <= arvalid && arready;
    r_hs      <= rvalid && rready;
    ar_addr_s <= araddr;
  end

  // memory responder and decode-side stimulus
  always @(posedge aclk) begin
    #1;
    if (ar_hs) begin
      bursts.push_back(ar_addr_s);
    end
    if (r_hs) begin
      if (beat == 3) begin
        void'(bursts.pop_front());
        beat = 0;
      end else begin
        beat++;
      end
    end
    arready = (take_bits(2) != 0);
    // a beat once offered stays until taken
    if (!(rvalid && !r_hs)) begin
      if (bursts.size() > 0 && take_bits(2) != 0) begin
        rvalid = 1'b1;
        rdata  = ~(bursts[0] + addr_t'(4 * beat));
        rlast  = (beat == 3);
      end else begin
        rvalid = 1'b0;
        rlast  = 1'b0;
      end
    end
    if (jumps_on && take_bits(5) == 0) begin
      jump_valid = 1'b1;
      jump_pc    = RESET_PC + (take_bits(10) << 2);
      jump_count++;
    end else begin
      jump_valid = 1'b0;
    end
    pop_sel = take_bits(2);
    if (stall || pop_sel == 0) begin
      pop_op = POP_NONE;
    end else if (pop_sel == 1) begin
      pop_op = POP_ONE;
    end else begin
      pop_op = POP_TWO;
    end
  end

  task automatic wait_pops(input int n, input int limit);
    int start;
    int cycles;
    start = popped;
    cycles = 0;
    while (popped < start + n && cycles < limit) begin
      @(posedge aclk);
      cycles++;
    end
    if (popped < start + n) begin
      $display("timeout: only %0d of %0d instructions popped within %0d cycles",
               popped - start, n, limit);
      test_bad = 1'b1;
    end
  endtask

  task automatic start_test();
    err_base = errors;
    test_bad = 1'b0;
  endtask

  task automatic end_test(input string name);
    if (test_bad || errors != err_base) begin
      fails++;
      $display("%-14s FAIL, %0d errors", name, errors - err_base);
    end else begin
      $display("%-14s ok", name);
    end
  endtask

  initial begin
    lfsr       = 32'd3016;
    reset      = 1'b1;
    jump_valid = 1'b0;
    jump_pc    = '0;
    pop_op     = POP_NONE;
    arready    = 1'b0;
    rvalid     = 1'b0;
    rdata      = '0;
    rlast      = 1'b0;
    ar_hs      = 1'b0;
    r_hs       = 1'b0;
    beat       = 0;
    stall      = 1'b0;
    jumps_on   = 1'b0;
    jump_count = 0;
    fails      = 0;

    start_test();
    repeat (2) @(posedge aclk);
    #1 reset = 1'b0;
    wait_pops(4, 200);
    end_test("reset");

    start_test();
    wait_pops(100, 3000);
    end_test("sequential");

    // buffer fills and fetch has to stall
    start_test();
    stall = 1'b1;
    repeat (300) @(posedge aclk);
    stall = 1'b0;
    wait_pops(40, 2000);
    end_test("decode stall");

    start_test();
    jumps_on = 1'b1;
    wait_pops(200, 10000);
    jumps_on = 1'b0;
    if (jump_count == 0) begin
      $display("no redirect was issued during the redirect run");
      test_bad = 1'b1;
    end
    end_test("redirects");

    $display("tests 4, failing %0d, check errors %0d, popped %0d, redirects %0d",
             fails, errors, popped, jump_count);
    if (fails == 0 && errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- tb.f
common/fetch_pkg.sv
fetch/fetch_pc_gen.sv
fetch/axi_fetch_bridge.sv
fetch/instr_buffer.sv
rtl/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv
